// File: include/lg_defines.svh
/* logic generator shared parameters
   data and counter widths, event and trigger counts, register map */
`ifndef LG_DEFINES_SVH
`define LG_DEFINES_SVH

`define LG_DW   8   // output word width
`define LG_TAW  6   // table address width, 64 entries
`define LG_CWR  8   // repeat counter
`define LG_CWL  16  // period length counter
`define LG_CWN  16  // burst number counter
`define LG_EN   4   // event inputs
`define LG_TN   4   // trigger inputs
`define LG_BAW  7   // decoded register address bits

// register offsets within the LG_BAW window
`define LG_REG_EVN_CTL 7'h00
`define LG_REG_EVN_SEL 7'h04
`define LG_REG_TRG     7'h08
`define LG_REG_MODE    7'h10
`define LG_REG_BDR     7'h20
`define LG_REG_BDL     7'h24
`define LG_REG_BPL     7'h28
`define LG_REG_BPN     7'h2C
`define LG_REG_STS_BPL 7'h30
`define LG_REG_STS_BPN 7'h34
`define LG_REG_OE0     7'h40
`define LG_REG_OE1     7'h44
`define LG_REG_MSK     7'h48
`define LG_REG_VAL     7'h4C

`endif

// File: source/lg_pkg.sv
/* logic generator types
   CPU bus request and response, configuration, events, sequencer states */
`include "lg_defines.svh"

package lg_pkg;

  // one CPU access, held by the requester until ack
  typedef struct packed {
    logic        wen;
    logic        ren;
    logic [15:0] addr;   // byte address
    logic [31:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic        ack;
    logic        err;    // never set
    logic [31:0] rdata;
  } bus_rsp_t;

  // event strobes, reset sits in bit 0
  typedef struct packed {
    logic swt;    // software trigger
    logic stop;   // reads back as idle
    logic start;  // reads back as running
    logic reset;
  } evn_t;

  typedef struct packed {
    logic               inf;  // infinite bursts
    logic               tre;  // rearm after each period
    logic [`LG_CWR-1:0] bdr;  // repeats per entry - 1
    logic [`LG_TAW-1:0] bdl;  // entries per burst - 1
    logic [`LG_CWL-1:0] bpl;  // period length - 1
    logic [`LG_CWN-1:0] bpn;  // burst count - 1
    logic [`LG_DW-1:0]  oe0;  // enable where output is 0
    logic [`LG_DW-1:0]  oe1;  // enable where output is 1
    logic [`LG_DW-1:0]  msk;
    logic [`LG_DW-1:0]  val;  // polarity
  } lg_cfg_t;

  typedef enum logic [1:0] {
    IDLE,
    ARMED,
    DATA,
    GAP
  } gen_state_e;

endpackage

// File: source/lg_regs.sv
/* logic generator register file
   holds the burst and output configuration, event select and trigger mask,
   pulses software events and returns status counters on reads */
`timescale 1ns/10ps
`include "lg_defines.svh"

module lg_regs (
  input  logic                          bus,
  input  logic                          arst_n,
  input  lg_pkg::bus_req_t              req,
  output lg_pkg::bus_rsp_t              rsp,
  input  lg_pkg::evn_t    [`LG_EN-1:0]  evi,
  input  logic            [`LG_TN-1:0]  trg,
  input  logic            [`LG_CWL-1:0] sts_bpl,
  input  logic            [`LG_CWN-1:0] sts_bpn,
  input  logic                          running,
  output lg_pkg::lg_cfg_t               cfg,
  output lg_pkg::evn_t                  evn,
  output logic                          ctl_trg,
  output lg_pkg::evn_t                  evo
);

  import lg_pkg::*;

  localparam int unsigned EL = $clog2(`LG_EN);  // event select width

  logic [`LG_BAW-1:0] adr;       // decoded part of the address
  logic               wr;
  logic [EL-1:0]      cfg_evn;   // event input select
  logic [`LG_TN-1:0]  cfg_trg;   // trigger enables
  evn_t               evn_sel;   // selected input, registered
  evn_t               evs;       // status view of 0x00
  logic               ack_q;
  logic [31:0]        rdata_q;

  assign adr = req.addr[`LG_BAW-1:0];
  assign wr  = req.wen;

  ////////////////////////////////////////////////////////////////////////////
  // bus response
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req.wen | req.ren;  // every access acked next cycle
    end
  end

  assign rsp = '{ack: ack_q, err: 1'b0, rdata: rdata_q};

  ////////////////////////////////////////////////////////////////////////////
  // configuration writes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      cfg     <= '0;
      cfg_evn <= '0;
      cfg_trg <= '0;
    end else if (wr) begin
      case (adr)
        `LG_REG_EVN_SEL: cfg_evn <= req.wdata[EL-1:0];
        `LG_REG_TRG: begin
          cfg_trg <= req.wdata[`LG_TN-1:0];
          cfg.tre <= req.wdata[31];       // repeat bit on top
        end
        `LG_REG_MODE: cfg.inf <= req.wdata[1];  // bit 0 unused
        `LG_REG_BDR:  cfg.bdr <= req.wdata[`LG_CWR-1:0];
        `LG_REG_BDL:  cfg.bdl <= req.wdata[`LG_TAW-1:0];
        `LG_REG_BPL:  cfg.bpl <= req.wdata[`LG_CWL-1:0];
        `LG_REG_BPN:  cfg.bpn <= req.wdata[`LG_CWN-1:0];
        `LG_REG_OE0:  cfg.oe0 <= req.wdata[`LG_DW-1:0];
        `LG_REG_OE1:  cfg.oe1 <= req.wdata[`LG_DW-1:0];
        `LG_REG_MSK:  cfg.msk <= req.wdata[`LG_DW-1:0];
        `LG_REG_VAL:  cfg.val <= req.wdata[`LG_DW-1:0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // events and triggers
  ////////////////////////////////////////////////////////////////////////////

  // software event pulses, one cycle per write to 0x00
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      evo     <= '0;
      evn_sel <= '0;
    end else begin
      evo     <= (wr && adr == `LG_REG_EVN_CTL) ? req.wdata[$bits(evn_t)-1:0] : '0;
      evn_sel <= evi[cfg_evn];
    end
  end

  assign evn     = evn_sel | evo;         // hardware or software source
  assign ctl_trg = |(trg & cfg_trg);      // masked triggers

  assign evs = '{swt: 1'b0, stop: ~running, start: running, reset: 1'b0};

  ////////////////////////////////////////////////////////////////////////////
  // read data
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (req.ren) begin
      case (adr)
        `LG_REG_EVN_CTL: rdata_q <= 32'(evs);
        `LG_REG_EVN_SEL: rdata_q <= 32'(cfg_evn);
        `LG_REG_TRG:     rdata_q <= 32'(cfg_trg) | (32'(cfg.tre) << 31);
        `LG_REG_MODE:    rdata_q <= 32'(cfg.inf) << 1;
        `LG_REG_BDR:     rdata_q <= 32'(cfg.bdr);
        `LG_REG_BDL:     rdata_q <= 32'(cfg.bdl);
        `LG_REG_BPL:     rdata_q <= 32'(cfg.bpl);
        `LG_REG_BPN:     rdata_q <= 32'(cfg.bpn);
        `LG_REG_STS_BPL: rdata_q <= 32'(sts_bpl);   // live counters
        `LG_REG_STS_BPN: rdata_q <= 32'(sts_bpn);
        `LG_REG_OE0:     rdata_q <= 32'(cfg.oe0);
        `LG_REG_OE1:     rdata_q <= 32'(cfg.oe1);
        `LG_REG_MSK:     rdata_q <= 32'(cfg.msk);
        `LG_REG_VAL:     rdata_q <= 32'(cfg.val);
        default:         rdata_q <= '0;
      endcase
    end
  end

endmodule

// File: source/lg_tbl_arb.sv
/* pattern table arbiter
   the sequencer read port has fixed priority, the CPU window gets idle
   cycles; ack comes with the registered RAM data one cycle after grant */
`timescale 1ns/10ps
`include "lg_defines.svh"

module lg_tbl_arb (
  input  logic                bus,
  input  logic                arst_n,
  input  logic                seq_rd,
  input  logic [`LG_TAW-1:0]  seq_addr,
  input  lg_pkg::bus_req_t    cpu_req,
  output lg_pkg::bus_rsp_t    cpu_rsp,
  output logic                ram_en,
  output logic                ram_we,
  output logic [`LG_TAW-1:0]  ram_addr,
  output logic [`LG_DW-1:0]   ram_wdata,
  input  logic [`LG_DW-1:0]   ram_rdata
);

  logic cpu_vld;    // pending CPU access not yet served
  logic cpu_gnt;
  logic cpu_ack_q;  // grant went to the CPU last cycle
  logic cpu_blk_q;  // cycle after ack

  // held request is masked while its ack is out and one cycle beyond
  assign cpu_vld = (cpu_req.wen | cpu_req.ren) & ~cpu_ack_q & ~cpu_blk_q;
  assign cpu_gnt = cpu_vld & ~seq_rd;      // sequencer always wins

  assign ram_en    = seq_rd | cpu_gnt;
  assign ram_we    = cpu_gnt & cpu_req.wen;
  // table words sit on 32 bit boundaries of the CPU window
  assign ram_addr  = seq_rd ? seq_addr : cpu_req.addr[`LG_TAW+1:2];
  assign ram_wdata = cpu_req.wdata[`LG_DW-1:0];

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      cpu_ack_q <= 1'b0;
      cpu_blk_q <= 1'b0;
    end else begin
      cpu_ack_q <= cpu_gnt;
      cpu_blk_q <= cpu_ack_q;
    end
  end

  // RAM output is the CPU word in the ack cycle
  assign cpu_rsp = '{ack: cpu_ack_q, err: 1'b0, rdata: 32'(ram_rdata)};

endmodule

// File: source/lg_tbl_ram.sv
/* pattern table
   single port RAM, read before write, registered read data */
`timescale 1ns/10ps
`include "lg_defines.svh"

module lg_tbl_ram (
  input  logic               bus,
  input  logic               ram_en,
  input  logic               ram_we,
  input  logic [`LG_TAW-1:0] ram_addr,
  input  logic [`LG_DW-1:0]  ram_wdata,
  output logic [`LG_DW-1:0]  ram_rdata
);

  logic [`LG_DW-1:0] mem [2**`LG_TAW];

  always_ff @(posedge bus) begin
    if (ram_en) begin
      if (ram_we) begin
        mem[ram_addr] <= ram_wdata;
      end
      ram_rdata <= mem[ram_addr];  // old contents on a write
    end
  end

endmodule

// File: source/lg_burst.sv
/* burst sequencer
   FSM stepping entry repeats, table entries, period length and burst count,
   then the mask, polarity and output enable stage on the table words */
`timescale 1ns/10ps
`include "lg_defines.svh"

module lg_burst (
  input  logic                bus,
  input  logic                arst_n,
  input  lg_pkg::lg_cfg_t     cfg,
  input  lg_pkg::evn_t        evn,
  input  logic                ctl_trg,
  output logic                seq_rd,
  output logic [`LG_TAW-1:0]  seq_addr,
  input  logic [`LG_DW-1:0]   ram_rdata,
  output logic [`LG_DW-1:0]   lg_o,
  output logic [`LG_DW-1:0]   lg_e,
  output logic                lg_vld,
  output logic                tro,
  output logic                irq,
  output logic [`LG_CWL-1:0]  sts_bpl,
  output logic [`LG_CWN-1:0]  sts_bpn,
  output logic                running
);

  import lg_pkg::*;

  gen_state_e         state;
  logic [`LG_CWR-1:0] rpt_cnt;   // repeats of current entry
  logic [`LG_TAW-1:0] adr_cnt;   // current entry
  logic [`LG_CWL-1:0] bpl_cnt;   // cycles since period start
  logic [`LG_CWN-1:0] bpn_cnt;   // finished periods
  logic               ent_end;
  logic               data_end;
  logic               per_end;
  logic               bst_last;
  logic               trg_go;
  logic               kill;
  logic               rd_vld;    // ram_rdata due this cycle
  logic               vld_d1;    // DATA delayed by one
  logic [`LG_DW-1:0]  dat_o;
  logic [`LG_DW-1:0]  dat_e;

  ////////////////////////////////////////////////////////////////////////////
  // sequencer
  ////////////////////////////////////////////////////////////////////////////

  assign ent_end  = rpt_cnt == cfg.bdr;
  assign data_end = (state == DATA) && ent_end && (adr_cnt == cfg.bdl);  // last cycle
  // period over once bpl+1 cycles passed and all entries are out
  assign per_end  = (data_end || state == GAP) && (bpl_cnt >= cfg.bpl);
  assign bst_last = ~cfg.inf && (bpn_cnt == cfg.bpn);
  assign trg_go   = ctl_trg | evn.swt;
  assign kill     = evn.stop | evn.reset;   // abort from any state

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      state   <= IDLE;
      rpt_cnt <= '0;
      adr_cnt <= '0;
      bpl_cnt <= '0;
      bpn_cnt <= '0;
      tro     <= 1'b0;
      irq     <= 1'b0;
    end else begin
      tro <= 1'b0;
      irq <= 1'b0;
      if (kill) begin
        state   <= IDLE;
        rpt_cnt <= '0;
        adr_cnt <= '0;
      end else begin
        case (state)
          IDLE: if (evn.start) begin
            state   <= ARMED;
            bpl_cnt <= '0;
            bpn_cnt <= '0;
          end
          ARMED: if (trg_go) begin
            state   <= DATA;
            bpl_cnt <= '0;      // new period
            tro     <= 1'b1;
          end
          DATA, GAP: begin
            bpl_cnt <= bpl_cnt + 1'b1;
            if (state == DATA) begin
              if (ent_end) begin
                rpt_cnt <= '0;
                adr_cnt <= data_end ? '0 : adr_cnt + 1'b1;
              end else begin
                rpt_cnt <= rpt_cnt + 1'b1;
              end
              if (data_end) state <= GAP;
            end
            if (per_end) begin
              if (bst_last) begin
                state <= IDLE;  // final period done
                irq   <= 1'b1;
              end else begin
                bpn_cnt <= bpn_cnt + 1'b1;
                bpl_cnt <= '0;
                if (cfg.tre) begin
                  state <= ARMED;   // wait for next trigger
                end else begin
                  state <= DATA;
                  tro   <= 1'b1;
                end
              end
            end
          end
          default: state <= IDLE;
        endcase
      end
    end
  end

  // one read per entry, in its first cycle
  assign seq_rd   = (state == DATA) && (rpt_cnt == '0);
  assign seq_addr = adr_cnt;

  assign running = state != IDLE;
  assign sts_bpl = bpl_cnt;
  assign sts_bpn = bpn_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // output stage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      rd_vld <= 1'b0;
      vld_d1 <= 1'b0;
      lg_vld <= 1'b0;
    end else begin
      rd_vld <= seq_rd & ~kill;
      vld_d1 <= (state == DATA) & ~kill;
      lg_vld <= vld_d1 & ~kill;  // drops right after stop
    end
  end

  assign dat_o = cfg.val ^ (ram_rdata & ~cfg.msk);
  assign dat_e = (cfg.oe0 & ~dat_o) | (cfg.oe1 & dat_o);

  // word held for the repeats, next read may already be in flight
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      lg_o <= '0;
      lg_e <= '0;
    end else if (!vld_d1 || kill) begin
      lg_o <= '0;
      lg_e <= '0;
    end else if (rd_vld) begin
      lg_o <= dat_o;
      lg_e <= dat_e;
    end
  end

endmodule

// File: source/lg_top.sv
/* logic pattern generator top level
   register file, burst sequencer, table arbiter and pattern RAM */
`timescale 1ns/10ps
`include "lg_defines.svh"

module lg_top (
  input  logic                          bus,
  input  logic                          arst_n,
  input  lg_pkg::bus_req_t              reg_req,
  output lg_pkg::bus_rsp_t              reg_rsp,
  input  lg_pkg::bus_req_t              tbl_req,
  output lg_pkg::bus_rsp_t              tbl_rsp,
  input  lg_pkg::evn_t    [`LG_EN-1:0]  evi,
  input  logic            [`LG_TN-1:0]  trg,
  output logic            [`LG_DW-1:0]  lg_o,
  output logic            [`LG_DW-1:0]  lg_e,
  output logic                          lg_vld,
  output lg_pkg::evn_t                  evo,
  output logic                          tro,
  output logic                          irq
);

  import lg_pkg::*;

  lg_cfg_t            cfg;
  evn_t               evn;
  logic               ctl_trg;
  logic [`LG_CWL-1:0] sts_bpl;
  logic [`LG_CWN-1:0] sts_bpn;
  logic               running;
  // sequencer read port
  logic               seq_rd;
  logic [`LG_TAW-1:0] seq_addr;
  // RAM side of the arbiter
  logic               ram_en;
  logic               ram_we;
  logic [`LG_TAW-1:0] ram_addr;
  logic [`LG_DW-1:0]  ram_wdata;
  logic [`LG_DW-1:0]  ram_rdata;

  lg_regs u_regs (
    .bus, .arst_n, .req(reg_req), .rsp(reg_rsp), .evi, .trg,
    .sts_bpl, .sts_bpn, .running, .cfg, .evn, .ctl_trg, .evo
  );

  lg_burst u_burst (
    .bus, .arst_n, .cfg, .evn, .ctl_trg, .seq_rd, .seq_addr, .ram_rdata,
    .lg_o, .lg_e, .lg_vld, .tro, .irq, .sts_bpl, .sts_bpn, .running
  );

  lg_tbl_arb u_arb (
    .bus, .arst_n, .seq_rd, .seq_addr, .cpu_req(tbl_req), .cpu_rsp(tbl_rsp),
    .ram_en, .ram_we, .ram_addr, .ram_wdata, .ram_rdata
  );

  lg_tbl_ram u_ram (
    .bus, .ram_en, .ram_we, .ram_addr, .ram_wdata, .ram_rdata
  );

endmodule

// File: sim/lg_sva.sv
/* logic generator protocol assertions
   register ack timing, single cycle tro and irq, enable rule,
   no valid output before the first trigger */
`timescale 1ns/10ps
`include "lg_defines.svh"

module lg_sva (
  input logic                bus,
  input logic                arst_n,
  input lg_pkg::bus_req_t    reg_req,
  input lg_pkg::bus_rsp_t    reg_rsp,
  input lg_pkg::lg_cfg_t     cfg,
  input lg_pkg::evn_t        evn,
  input logic                ctl_trg,
  input logic [`LG_DW-1:0]   lg_o,
  input logic [`LG_DW-1:0]   lg_e,
  input logic                lg_vld,
  input logic                tro,
  input logic                irq
);

  import lg_pkg::*;

  logic trg_seen;   // any trigger since reset

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      trg_seen <= 1'b0;
    end else if (ctl_trg || evn.swt) begin
      trg_seen <= 1'b1;
    end
  end

  // ack exactly one cycle after each access
  a_ack: assert property (@(posedge bus) disable iff (!arst_n)
    (reg_req.wen || reg_req.ren) |=> reg_rsp.ack) else $error("register ack missing");
  a_no_ack: assert property (@(posedge bus) disable iff (!arst_n)
    !(reg_req.wen || reg_req.ren) |=> !reg_rsp.ack) else $error("spurious register ack");

  a_tro: assert property (@(posedge bus) disable iff (!arst_n)
    tro |=> !tro) else $error("tro wider than one cycle");
  a_irq: assert property (@(posedge bus) disable iff (!arst_n)
    irq |=> !irq) else $error("irq wider than one cycle");

  a_oe: assert property (@(posedge bus) disable iff (!arst_n)
    lg_vld |-> lg_e == ((cfg.oe0 & ~lg_o) | (cfg.oe1 & lg_o)))
    else $error("lg_e breaks the enable rule");

  a_vld: assert property (@(posedge bus) disable iff (!arst_n)
    lg_vld |-> trg_seen) else $error("lg_vld before any trigger");

endmodule

bind lg_top lg_sva u_sva (
  .bus, .arst_n, .reg_req, .reg_rsp, .cfg, .evn, .ctl_trg,
  .lg_o, .lg_e, .lg_vld, .tro, .irq
);

// File: sim/lg_tb.sv
/* logic generator testbench
   register and table access, burst playback against a table shadow,
   output stage, events and triggers, CPU table reads during playback */
`timescale 1ns/10ps
`include "lg_defines.svh"

module lg_tb;

  import lg_pkg::*;

  logic                      bus;
  logic                      arst_n;
  bus_req_t                  reg_req;
  bus_rsp_t                  reg_rsp;
  bus_req_t                  tbl_req;
  bus_rsp_t                  tbl_rsp;
  evn_t       [`LG_EN-1:0]   evi;
  logic       [`LG_TN-1:0]   trg;
  logic       [`LG_DW-1:0]   lg_o;
  logic       [`LG_DW-1:0]   lg_e;
  logic                      lg_vld;
  evn_t                      evo;
  logic                      tro;
  logic                      irq;

  logic [15:0]       lfsr_q = 16'd70;       // seed
  logic [`LG_DW-1:0] shadow [2**`LG_TAW];   // table copy
  logic [`LG_DW-1:0] s_msk, s_val, s_oe0, s_oe1;
  int                s_bdr, s_bdl;
  logic [`LG_DW-1:0] got_o [$];
  logic [`LG_DW-1:0] got_e [$];
  int                tro_cnt, irq_cnt, err_cnt;
  evn_t              evo_q;                 // evo at the previous sample

  // config registers and their writable bits
  logic [6:0]  ra [11] = '{7'h04, 7'h08, 7'h10, 7'h20, 7'h24, 7'h28,
                           7'h2C, 7'h40, 7'h44, 7'h48, 7'h4C};
  logic [31:0] rm [11] = '{32'h3, 32'h8000000F, 32'h2, 32'hFF, 32'h3F, 32'hFFFF,
                           32'hFFFF, 32'hFF, 32'hFF, 32'hFF, 32'hFF};

  lg_top u_dut (.*);

  initial begin
    bus = 1'b0;
    forever #10 bus = ~bus;
  end

  // 16 bit fibonacci with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[15]};   // one step per bit
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got, exp);
    err_cnt++;
    $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
    $display("Simulation finished: FAIL");
    $fatal(1, "check failed");
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Simulation finished: FAIL");
    $fatal(1, "timeout");
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge bus);
  endtask

  // outputs sampled mid cycle
  always @(negedge bus) begin
    if (arst_n) begin
      if (lg_vld) begin
        got_o.push_back(lg_o);
        got_e.push_back(lg_e);
      end else begin
        // parked at zero outside playback
        assert (lg_o == '0) else report_mismatch("lg_o", lg_o, 0);
        assert (lg_e == '0) else report_mismatch("lg_e", lg_e, 0);
      end
      // event pulses last a single cycle
      assert (evo == '0 || evo_q == '0) else report_mismatch("evo", evo, 0);
      evo_q = evo;
      if (tro) tro_cnt++;
      if (irq) irq_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic reg_access(input logic wr, input logic [6:0] a, input logic [31:0] d,
                            output logic [31:0] q);
    int         t;
    logic [3:0] evo_exp;   // written event bits, due with the ack
    evo_exp = (wr && a == `LG_REG_EVN_CTL) ? d[3:0] : 4'h0;
    @(negedge bus);
    reg_req = '{wen: wr, ren: ~wr, addr: 16'(a), wdata: d};
    t = 0;
    do begin
      @(negedge bus);
      if (++t > 8) report_timeout("register ack");
    end while (!reg_rsp.ack);
    assert (reg_rsp.err == 1'b0) else report_mismatch("reg_rsp.err", reg_rsp.err, 0);
    assert (evo == evo_exp) else report_mismatch("evo", evo, evo_exp);
    q       = reg_rsp.rdata;
    reg_req = '0;
  endtask

  task automatic reg_write(input logic [6:0] a, input logic [31:0] d);
    logic [31:0] q;
    reg_access(1'b1, a, d, q);
  endtask

  task automatic reg_read(input logic [6:0] a, output logic [31:0] q);
    reg_access(1'b0, a, '0, q);
  endtask

  task automatic reg_check(input logic [6:0] a, input logic [31:0] exp);
    logic [31:0] q;
    reg_read(a, q);
    assert (q == exp) else report_mismatch($sformatf("reg 0x%0h", a), q, exp);
  endtask

  task automatic tbl_access(input logic wr, input int idx, input logic [31:0] d,
                            output logic [31:0] q);
    int t;
    @(negedge bus);
    tbl_req = '{wen: wr, ren: ~wr, addr: 16'(idx * 4), wdata: d};
    t = 0;
    do begin
      @(negedge bus);
      if (++t > 100) report_timeout("table ack");
    end while (!tbl_rsp.ack);
    assert (tbl_rsp.err == 1'b0) else report_mismatch("tbl_rsp.err", tbl_rsp.err, 0);
    q       = tbl_rsp.rdata;
    tbl_req = '0;
  endtask

  task automatic tbl_write(input int idx, input logic [`LG_DW-1:0] d);
    logic [31:0] q;
    tbl_access(1'b1, idx, 32'(d), q);
    shadow[idx] = d;
  endtask

  task automatic tbl_read(input int idx);
    logic [31:0] q;
    tbl_access(1'b0, idx, '0, q);
    assert (q == 32'(shadow[idx])) else report_mismatch("tbl_rsp.rdata", q, shadow[idx]);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // playback model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [`LG_DW-1:0] model_o(input logic [`LG_DW-1:0] raw);
    return s_val ^ (raw & ~s_msk);
  endfunction

  task automatic wait_irq();
    int t = 0;
    while (irq_cnt == 0) begin
      @(negedge bus);
      if (++t > 3000) report_timeout("irq");
    end
  endtask

  task automatic cpu_reads();
    int          t = 0;
    logic [31:0] r;
    while (!tro) begin
      @(negedge bus);
      if (++t > 100) report_timeout("first tro");
    end
    wait_cycles(2);   // first request meets the read of entry 1
    repeat (16) begin
      rand_bits(`LG_TAW, r);
      tbl_read(int'(r));
    end
  endtask

  task automatic clear_monitor();
    got_o.delete();
    got_e.delete();
    tro_cnt = 0;
    irq_cnt = 0;
  endtask

  // start and software trigger then compare the whole stream
  task automatic play_check(input int nb, input bit with_cpu);
    logic [`LG_DW-1:0] o;
    int                k = 0;
    clear_monitor();
    fork
      begin
        reg_write(`LG_REG_EVN_CTL, 32'h2);
        reg_write(`LG_REG_EVN_CTL, 32'h8);
        wait_irq();
      end
      if (with_cpu) cpu_reads();
    join
    wait_cycles(4);
    assert (got_o.size() == nb * (s_bdl + 1) * (s_bdr + 1))
      else report_mismatch("lg_vld count", got_o.size(), nb * (s_bdl + 1) * (s_bdr + 1));
    for (int b = 0; b < nb; b++)
      for (int e = 0; e <= s_bdl; e++)
        for (int r = 0; r <= s_bdr; r++) begin
          o = model_o(shadow[e]);
          assert (got_o[k] == o) else report_mismatch("lg_o", got_o[k], o);
          assert (got_e[k] == ((s_oe0 & ~o) | (s_oe1 & o)))
            else report_mismatch("lg_e", got_e[k], (s_oe0 & ~o) | (s_oe1 & o));
          k++;
        end
    assert (tro_cnt == nb) else report_mismatch("tro count", tro_cnt, nb);
    assert (irq_cnt == 1) else report_mismatch("irq count", irq_cnt, 1);
    reg_check(`LG_REG_EVN_CTL, 32'h4);   // back to idle
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] v;
    int          t;
    reg_req = '0;
    tbl_req = '0;
    evi     = '0;
    trg     = '0;
    err_cnt = 0;
    evo_q   = '0;
    arst_n  = 1'b0;
    clear_monitor();
    repeat (5) @(negedge bus);
    arst_n = 1'b1;

    // config field readback and idle status
    reg_check(`LG_REG_STS_BPL, 32'h0);
    reg_check(`LG_REG_STS_BPN, 32'h0);
    foreach (ra[i]) begin
      rand_bits(32, v);
      reg_write(ra[i], v);
      reg_check(ra[i], v & rm[i]);
    end
    reg_write(`LG_REG_TRG, 32'h0);
    reg_write(`LG_REG_MODE, 32'h0);

    // table fill and readback
    for (int i = 0; i < 2**`LG_TAW; i++) begin
      rand_bits(`LG_DW, v);
      tbl_write(i, v[`LG_DW-1:0]);
    end
    for (int i = 0; i < 2**`LG_TAW; i++) tbl_read(i);

    // plain playback over 3 bursts
    s_msk = '0;
    s_val = '0;
    s_oe0 = '0;
    s_oe1 = '0;
    s_bdr = 2;
    s_bdl = 5;
    foreach (ra[i]) if (ra[i] >= 7'h40) reg_write(ra[i], 32'h0);
    reg_write(`LG_REG_BDR, 2);
    reg_write(`LG_REG_BDL, 5);
    reg_write(`LG_REG_BPL, 30);
    reg_write(`LG_REG_BPN, 2);
    play_check(3, 1'b0);

    // same stream with CPU table reads in between
    play_check(3, 1'b1);

    // mask, polarity and enables
    rand_bits(8, v);
    s_msk = v[7:0];
    rand_bits(8, v);
    s_val = v[7:0];
    rand_bits(8, v);
    s_oe0 = v[7:0];
    rand_bits(8, v);
    s_oe1 = v[7:0];
    reg_write(`LG_REG_MSK, s_msk);
    reg_write(`LG_REG_VAL, s_val);
    reg_write(`LG_REG_OE0, s_oe0);
    reg_write(`LG_REG_OE1, s_oe1);
    reg_write(`LG_REG_BPN, 0);
    play_check(1, 1'b0);

    // masked trigger line is ignored and the enabled line starts
    clear_monitor();
    reg_write(`LG_REG_TRG, 32'h1);
    reg_write(`LG_REG_EVN_CTL, 32'h2);
    trg = 4'b0010;
    wait_cycles(12);
    assert (tro_cnt == 0) else report_mismatch("tro count", tro_cnt, 0);
    trg = 4'b0001;
    t   = 0;
    while (tro_cnt == 0) begin
      @(negedge bus);
      if (++t > 20) report_timeout("hardware trigger start");
    end
    trg = '0;
    wait_irq();

    // infinite bursts ended by stop
    clear_monitor();
    reg_write(`LG_REG_MODE, 32'h2);
    reg_write(`LG_REG_EVN_CTL, 32'h2);
    reg_write(`LG_REG_EVN_CTL, 32'h8);
    t = 0;
    while (!lg_vld) begin
      @(negedge bus);
      if (++t > 20) report_timeout("lg_vld rise");
    end
    wait_cycles(40);
    reg_write(`LG_REG_EVN_CTL, 32'h4);
    t = 0;
    while (lg_vld) begin
      @(negedge bus);
      if (++t > 4) report_timeout("lg_vld fall after stop");
    end
    assert (irq_cnt == 0) else report_mismatch("irq count", irq_cnt, 0);
    reg_check(`LG_REG_EVN_CTL, 32'h4);
    reg_write(`LG_REG_MODE, 32'h0);

    wait_cycles(5);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
source/lg_pkg.sv
source/lg_regs.sv
source/lg_tbl_arb.sv
source/lg_tbl_ram.sv
source/lg_burst.sv
source/lg_top.sv
sim/lg_sva.sv
sim/lg_tb.sv

// File: Bender.yml
package:
  name: lg

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/lg_pkg.sv
      - source/lg_regs.sv
      - source/lg_tbl_arb.sv
      - source/lg_tbl_ram.sv
      - source/lg_burst.sv
      - source/lg_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/lg_sva.sv
      - sim/lg_tb.sv
